/* rtl/vchess_ctrl_pkg.sv */
package vchess_ctrl_pkg;

   localparam int SIDE_WIDTH      = 32;
   localparam int BOARD_SIDES     = 8;
   localparam int BOARD_WIDTH     = SIDE_WIDTH * BOARD_SIDES;
   localparam int ADDR_WIDTH      = 16;
   localparam int DATA_WIDTH      = 32;
   localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;   // AXI byte address down to word address

   // Word addresses of the register map
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_CONTROL     = 14'd0;
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_MOVE_INDEX  = 14'd1;
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_POSITION    = 14'd2;
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_HALF_MOVE   = 14'd3;
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_CAPTURE     = 14'd4;
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_BOARD       = 14'd8;   // First of eight
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_MOVE_EVAL   = 14'd134;
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_MOVE_COUNT  = 14'd135;
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_ROOT_EVAL   = 14'd136;
   localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_MISC_STATUS = 14'd255;

   typedef enum logic [3:0] {
      SEL_CONTROL,
      SEL_MOVE_INDEX,
      SEL_POSITION,
      SEL_HALF_MOVE,
      SEL_CAPTURE,
      SEL_BOARD,
      SEL_MOVE_EVAL,
      SEL_MOVE_COUNT,
      SEL_ROOT_EVAL,
      SEL_MISC_STATUS,
      SEL_NONE
   } reg_sel_e;

   typedef struct packed {
      logic [BOARD_WIDTH-1:0] board;
      logic                   white_to_move;
      logic [3:0]             castle_mask;
      logic [3:0]             en_passant_col;
   } position_t;

   typedef struct packed {
      logic new_board_valid;
      logic clear_moves;
      logic capture_moves;
      logic use_random_bit;
      logic soft_reset;
   } ctrl_flags_t;

   typedef struct packed {
      logic idle;
      logic moves_ready;
      logic move_ready;   // Indexed move eval valid
      logic mate;
      logic stalemate;
   } status_flags_t;

   typedef struct packed {
      logic [WORD_ADDR_WIDTH-1:0] word_addr;
      logic [DATA_WIDTH-1:0]      data;
   } wr_cmd_t;

endpackage

/* rtl/ctrl_axi_write.sv */
`timescale 1ns/1ps

module ctrl_axi_write
   import vchess_ctrl_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,

   input  logic [ADDR_WIDTH-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [DATA_WIDTH-1:0] wdata,
   input  logic                  wvalid,
   output logic                  wready,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [1:0]            bresp,

   output logic                  wr_valid,
   output wr_cmd_t               wr_cmd
);

   logic                  aw_held;
   logic                  w_held;
   logic [ADDR_WIDTH-1:0] aw_buf;
   logic [DATA_WIDTH-1:0] w_buf;
   logic                  aw_fire;
   logic                  w_fire;

   // One address and one data beat per write response
   assign awready = !aw_held && !bvalid;
   assign wready  = !w_held && !bvalid;
   assign aw_fire = awvalid && awready;
   assign w_fire  = wvalid && wready;

   assign wr_valid         = aw_held && w_held;
   assign wr_cmd.word_addr = aw_buf[ADDR_WIDTH-1:2];
   assign wr_cmd.data      = w_buf;
   assign bresp            = 2'b00;   // Always OKAY

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         aw_held <= 1'b0;
         w_held  <= 1'b0;
         bvalid  <= 1'b0;
      end
      else
      begin
         if (wr_valid)
         begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
         end
         else
         begin
            if (aw_fire)
               aw_held <= 1'b1;
            if (w_fire)
               w_held <= 1'b1;
         end

         if (wr_valid)
            bvalid <= 1'b1;   // Same edge as the register update
         else if (bready)
            bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (aw_fire)
         aw_buf <= awaddr;
      if (w_fire)
         w_buf <= wdata;
   end

endmodule

/* rtl/ctrl_reg_decode.sv */
`timescale 1ns/1ps

module ctrl_reg_decode
   import vchess_ctrl_pkg::*;
(
   input  logic [WORD_ADDR_WIDTH-1:0]     word_addr,
   output reg_sel_e                       sel,
   output logic [$clog2(BOARD_SIDES)-1:0] board_word
);

   logic [WORD_ADDR_WIDTH-1:0] board_offset;
   logic                       in_board;

   assign board_offset = word_addr - ADDR_BOARD;
   assign in_board     = (word_addr >= ADDR_BOARD) &&
                         (board_offset < WORD_ADDR_WIDTH'(BOARD_SIDES));
   assign board_word   = board_offset[$clog2(BOARD_SIDES)-1:0];

   always_comb
   begin
      if (in_board)
      begin
         sel = SEL_BOARD;
      end
      else
      begin
         case (word_addr)
            ADDR_CONTROL:     sel = SEL_CONTROL;
            ADDR_MOVE_INDEX:  sel = SEL_MOVE_INDEX;
            ADDR_POSITION:    sel = SEL_POSITION;
            ADDR_HALF_MOVE:   sel = SEL_HALF_MOVE;
            ADDR_CAPTURE:     sel = SEL_CAPTURE;
            ADDR_MOVE_EVAL:   sel = SEL_MOVE_EVAL;
            ADDR_MOVE_COUNT:  sel = SEL_MOVE_COUNT;
            ADDR_ROOT_EVAL:   sel = SEL_ROOT_EVAL;
            ADDR_MISC_STATUS: sel = SEL_MISC_STATUS;
            default:          sel = SEL_NONE;   // Holes in the map
         endcase
      end
   end

endmodule

/* rtl/ctrl_reg_bank.sv */
`timescale 1ns/1ps

module ctrl_reg_bank
   import vchess_ctrl_pkg::*;
#(
   parameter int MAX_POSITIONS_LOG2 = 7,
   parameter int HALF_MOVE_WIDTH    = 7
)
(
   input  logic                           clk,
   input  logic                           rst,

   input  logic                           wr_valid,
   input  logic [DATA_WIDTH-1:0]          wr_data,
   input  reg_sel_e                       sel,
   input  logic [$clog2(BOARD_SIDES)-1:0] board_word,

   output ctrl_flags_t                    ctrl,
   output position_t                      position,
   output logic [MAX_POSITIONS_LOG2-1:0]  move_index,
   output logic [HALF_MOVE_WIDTH-1:0]     half_move
);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ctrl       <= '0;
         position   <= '0;
         move_index <= '0;
         half_move  <= '0;
      end
      else if (wr_valid)
      begin
         case (sel)
            SEL_CONTROL:
            begin
               // Capture flag lives in its own register
               ctrl.new_board_valid <= wr_data[0];
               ctrl.clear_moves     <= wr_data[1];
               ctrl.use_random_bit  <= wr_data[30];
               ctrl.soft_reset      <= wr_data[31];
            end
            SEL_MOVE_INDEX:
            begin
               move_index <= wr_data[MAX_POSITIONS_LOG2-1:0];
            end
            SEL_POSITION:
            begin
               position.white_to_move  <= wr_data[8];
               position.castle_mask    <= wr_data[7:4];
               position.en_passant_col <= wr_data[3:0];
            end
            SEL_HALF_MOVE:
            begin
               half_move <= wr_data[HALF_MOVE_WIDTH-1:0];
            end
            SEL_CAPTURE:
            begin
               ctrl.capture_moves <= wr_data[0];
            end
            SEL_BOARD:
            begin
               // Word k fills bits 32k upward
               position.board[board_word * SIDE_WIDTH +: SIDE_WIDTH] <= wr_data[SIDE_WIDTH-1:0];
            end
            default:
            begin
               // Read-only or unmapped
            end
         endcase
      end
   end

endmodule

/* rtl/ctrl_read_result.sv */
`timescale 1ns/1ps

module ctrl_read_result
   import vchess_ctrl_pkg::*;
#(
   parameter int EVAL_WIDTH         = 16,
   parameter int MAX_POSITIONS_LOG2 = 7,
   parameter int HALF_MOVE_WIDTH    = 7
)
(
   input  logic                           clk,
   input  logic                           rst,

   input  logic                           arvalid,
   output logic                           arready,
   output logic [DATA_WIDTH-1:0]          rdata,
   output logic                           rvalid,
   input  logic                           rready,
   output logic [1:0]                     rresp,

   input  reg_sel_e                       sel,
   input  logic [$clog2(BOARD_SIDES)-1:0] board_word,

   input  ctrl_flags_t                    ctrl,
   input  position_t                      position,
   input  logic [MAX_POSITIONS_LOG2-1:0]  move_index,
   input  logic [HALF_MOVE_WIDTH-1:0]     half_move,

   input  status_flags_t                  status,
   input  logic [MAX_POSITIONS_LOG2-1:0]  move_count,
   input  logic signed [EVAL_WIDTH-1:0]   move_eval,
   input  logic signed [EVAL_WIDTH-1:0]   root_eval,
   input  logic [31:0]                    misc_status
);

   logic [DATA_WIDTH-1:0] rd_word;

   assign arready = 1'b1;
   assign rresp   = 2'b00;

   always_comb
   begin
      rd_word = '0;
      case (sel)
         SEL_CONTROL:
         begin
            rd_word[0]  = ctrl.new_board_valid;
            rd_word[1]  = ctrl.clear_moves;
            rd_word[2]  = status.moves_ready;
            rd_word[3]  = status.move_ready;
            rd_word[4]  = status.stalemate;
            rd_word[5]  = status.mate;
            rd_word[7]  = status.idle;
            rd_word[30] = ctrl.use_random_bit;
            rd_word[31] = ctrl.soft_reset;
         end
         SEL_MOVE_INDEX:  rd_word = DATA_WIDTH'(move_index);
         SEL_POSITION:
            rd_word[8:0] = {position.white_to_move, position.castle_mask, position.en_passant_col};
         SEL_HALF_MOVE:   rd_word = DATA_WIDTH'(half_move);
         SEL_CAPTURE:     rd_word[0] = ctrl.capture_moves;
         SEL_BOARD:       rd_word = position.board[board_word * SIDE_WIDTH +: SIDE_WIDTH];
         SEL_MOVE_EVAL:   rd_word = {{(DATA_WIDTH - EVAL_WIDTH){move_eval[EVAL_WIDTH-1]}}, move_eval};
         SEL_MOVE_COUNT:  rd_word = DATA_WIDTH'(move_count);
         SEL_ROOT_EVAL:   rd_word = {{(DATA_WIDTH - EVAL_WIDTH){root_eval[EVAL_WIDTH-1]}}, root_eval};
         SEL_MISC_STATUS: rd_word = misc_status;
         default:         rd_word = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         rvalid <= 1'b0;
      else if (arvalid)
         rvalid <= 1'b1;   // New request wins over rready
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (arvalid)
         rdata <= rd_word;
   end

endmodule

/* rtl/vchess_ctrl_top.sv */
`timescale 1ns/1ps

module vchess_ctrl_top
   import vchess_ctrl_pkg::*;
#(
   parameter int EVAL_WIDTH         = 16,
   parameter int MAX_POSITIONS_LOG2 = 7,
   parameter int HALF_MOVE_WIDTH    = 7
)
(
   input  logic                          clk,
   input  logic                          rst,

   input  logic [ADDR_WIDTH-1:0]         awaddr,
   input  logic                          awvalid,
   output logic                          awready,
   input  logic [DATA_WIDTH-1:0]         wdata,
   input  logic                          wvalid,
   output logic                          wready,
   output logic                          bvalid,
   input  logic                          bready,
   output logic [1:0]                    bresp,

   input  logic [ADDR_WIDTH-1:0]         araddr,
   input  logic                          arvalid,
   output logic                          arready,
   output logic [31:0]                   rdata,
   output logic                          rvalid,
   input  logic                          rready,
   output logic [1:0]                    rresp,

   input  status_flags_t                 status,
   input  logic [MAX_POSITIONS_LOG2-1:0] move_count,
   input  logic signed [EVAL_WIDTH-1:0]  move_eval,
   input  logic signed [EVAL_WIDTH-1:0]  root_eval,
   input  logic [31:0]                   misc_status,

   output ctrl_flags_t                   ctrl,
   output position_t                     position,
   output logic [MAX_POSITIONS_LOG2-1:0] move_index,
   output logic [HALF_MOVE_WIDTH-1:0]    half_move
);

   logic                           wr_valid;
   wr_cmd_t                        wr_cmd;
   reg_sel_e                       wr_sel;
   logic [$clog2(BOARD_SIDES)-1:0] wr_board_word;
   reg_sel_e                       rd_sel;
   logic [$clog2(BOARD_SIDES)-1:0] rd_board_word;

   ctrl_axi_write i_axi_write (
      .clk      (clk),
      .rst      (rst),
      .awaddr   (awaddr),
      .awvalid  (awvalid),
      .awready  (awready),
      .wdata    (wdata),
      .wvalid   (wvalid),
      .wready   (wready),
      .bvalid   (bvalid),
      .bready   (bready),
      .bresp    (bresp),
      .wr_valid (wr_valid),
      .wr_cmd   (wr_cmd)
   );

   ctrl_reg_decode i_wr_decode (
      .word_addr  (wr_cmd.word_addr),
      .sel        (wr_sel),
      .board_word (wr_board_word)
   );

   ctrl_reg_decode i_rd_decode (
      .word_addr  (araddr[ADDR_WIDTH-1:2]),   // Byte to word address
      .sel        (rd_sel),
      .board_word (rd_board_word)
   );

   ctrl_reg_bank #(
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2),
      .HALF_MOVE_WIDTH    (HALF_MOVE_WIDTH)
   ) i_reg_bank (
      .clk        (clk),
      .rst        (rst),
      .wr_valid   (wr_valid),
      .wr_data    (wr_cmd.data),
      .sel        (wr_sel),
      .board_word (wr_board_word),
      .ctrl       (ctrl),
      .position   (position),
      .move_index (move_index),
      .half_move  (half_move)
   );

   ctrl_read_result #(
      .EVAL_WIDTH         (EVAL_WIDTH),
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2),
      .HALF_MOVE_WIDTH    (HALF_MOVE_WIDTH)
   ) i_read_result (
      .clk         (clk),
      .rst         (rst),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rvalid      (rvalid),
      .rready      (rready),
      .rresp       (rresp),
      .sel         (rd_sel),
      .board_word  (rd_board_word),
      .ctrl        (ctrl),
      .position    (position),
      .move_index  (move_index),
      .half_move   (half_move),
      .status      (status),
      .move_count  (move_count),
      .move_eval   (move_eval),
      .root_eval   (root_eval),
      .misc_status (misc_status)
   );

endmodule

/* sim/tb_vchess_ctrl_chk.sv */
`timescale 1ns/1ps

module tb_vchess_ctrl_chk
   import vchess_ctrl_pkg::*;
(
   input logic        clk,
   input logic        rst,
   input logic        awready,
   input logic        bvalid,
   input logic        bready,
   input logic        arvalid,
   input logic        rvalid,
   input ctrl_flags_t ctrl
);

   bvalid_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped without bready");

   // No new address while a response is pending
   aw_blocked: assert property (@(posedge clk) disable iff (rst)
      bvalid |-> !awready)
      else $error("awready high while bvalid is high");

   read_latency: assert property (@(posedge clk) disable iff (rst)
      arvalid |=> rvalid)
      else $error("rvalid did not follow arvalid");

   ctrl_after_reset: assert property (@(posedge clk)
      rst |=> (ctrl == '0))
      else $error("ctrl not zero after reset");

endmodule

bind vchess_ctrl_top tb_vchess_ctrl_chk i_chk (
   .clk     (clk),
   .rst     (rst),
   .awready (awready),
   .bvalid  (bvalid),
   .bready  (bready),
   .arvalid (arvalid),
   .rvalid  (rvalid),
   .ctrl    (ctrl)
);

/* sim/tb_vchess_ctrl.sv */
`timescale 1ns/1ps

module tb_vchess_ctrl
   import vchess_ctrl_pkg::*;
();

   localparam int EVAL_WIDTH         = 16;
   localparam int MAX_POSITIONS_LOG2 = 7;
   localparam int HALF_MOVE_WIDTH    = 7;
   localparam int TIMEOUT_CYCLES     = 10_000;   // About 600 transactions of up to 16 cycles

   logic                          clk = 1'b0;
   logic                          rst;
   logic [ADDR_WIDTH-1:0]         awaddr;
   logic                          awvalid;
   logic                          awready;
   logic [DATA_WIDTH-1:0]         wdata;
   logic                          wvalid;
   logic                          wready;
   logic                          bvalid;
   logic                          bready;
   logic [1:0]                    bresp;
   logic [ADDR_WIDTH-1:0]         araddr;
   logic                          arvalid;
   logic                          arready;
   logic [31:0]                   rdata;
   logic                          rvalid;
   logic                          rready;
   logic [1:0]                    rresp;
   status_flags_t                 status;
   logic [MAX_POSITIONS_LOG2-1:0] move_count;
   logic signed [EVAL_WIDTH-1:0]  move_eval;
   logic signed [EVAL_WIDTH-1:0]  root_eval;
   logic [31:0]                   misc_status;
   ctrl_flags_t                   ctrl;
   position_t                     position;
   logic [MAX_POSITIONS_LOG2-1:0] move_index;
   logic [HALF_MOVE_WIDTH-1:0]    half_move;

   // Register model
   ctrl_flags_t                   exp_ctrl;
   position_t                     exp_pos;
   logic [MAX_POSITIONS_LOG2-1:0] exp_move_index;
   logic [HALF_MOVE_WIDTH-1:0]    exp_half_move;

   logic [31:0] rnd_state = 32'h3fc9_a740;
   int          cycle_count = 0;

   vchess_ctrl_top #(
      .EVAL_WIDTH         (EVAL_WIDTH),
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2),
      .HALF_MOVE_WIDTH    (HALF_MOVE_WIDTH)
   ) i_dut (
      .clk         (clk),
      .rst         (rst),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wvalid      (wvalid),
      .wready      (wready),
      .bvalid      (bvalid),
      .bready      (bready),
      .bresp       (bresp),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rvalid      (rvalid),
      .rready      (rready),
      .rresp       (rresp),
      .status      (status),
      .move_count  (move_count),
      .move_eval   (move_eval),
      .root_eval   (root_eval),
      .misc_status (misc_status),
      .ctrl        (ctrl),
      .position    (position),
      .move_index  (move_index),
      .half_move   (half_move)
   );

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic fail_run(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      abort_run();
   endtask

   task automatic check_value(input string name, input logic [264:0] expected,
                              input logic [264:0] actual);
      assert (actual === expected)
      else
      begin
         $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
         abort_run();
      end
   endtask

   function automatic logic [31:0] lcg_next();
      rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
      return rnd_state;
   endfunction

   // Upper halves only since the low LCG bits repeat quickly
   function automatic logic [31:0] rand_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next();
      lo = lcg_next();
      return {hi[31:16], lo[31:16]};
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = lcg_next();
      return int'(r[31:16]) % n;
   endfunction

   function automatic void apply_write(input logic [13:0] word_addr, input logic [31:0] data);
      int k;
      k = int'(word_addr) - 8;
      case (word_addr)
         14'd0:
         begin
            exp_ctrl.new_board_valid = data[0];
            exp_ctrl.clear_moves     = data[1];
            exp_ctrl.use_random_bit  = data[30];
            exp_ctrl.soft_reset      = data[31];
         end
         14'd1: exp_move_index = data[MAX_POSITIONS_LOG2-1:0];
         14'd2:
         begin
            exp_pos.white_to_move  = data[8];
            exp_pos.castle_mask    = data[7:4];
            exp_pos.en_passant_col = data[3:0];
         end
         14'd3: exp_half_move = data[HALF_MOVE_WIDTH-1:0];
         14'd4: exp_ctrl.capture_moves = data[0];
         default:
         begin
            if (k >= 0 && k < 8)
               exp_pos.board[k*32 +: 32] = data;   // Read-only and holes fall through
         end
      endcase
   endfunction

   function automatic logic [31:0] expected_read(input logic [13:0] word_addr);
      logic [31:0] word;
      int          k;
      word = '0;
      k    = int'(word_addr) - 8;
      if (k >= 0 && k < 8)
         word = exp_pos.board[k*32 +: 32];
      else
      begin
         case (word_addr)
            14'd0:
            begin
               word[0]  = exp_ctrl.new_board_valid;
               word[1]  = exp_ctrl.clear_moves;
               word[2]  = status.moves_ready;
               word[3]  = status.move_ready;
               word[4]  = status.stalemate;
               word[5]  = status.mate;
               word[7]  = status.idle;
               word[30] = exp_ctrl.use_random_bit;
               word[31] = exp_ctrl.soft_reset;
            end
            14'd1: word[MAX_POSITIONS_LOG2-1:0] = exp_move_index;
            14'd2: word[8:0] = {exp_pos.white_to_move, exp_pos.castle_mask,
                                exp_pos.en_passant_col};
            14'd3: word[HALF_MOVE_WIDTH-1:0] = exp_half_move;
            14'd4: word[0] = exp_ctrl.capture_moves;
            14'd134: word = {{16{move_eval[15]}}, move_eval};
            14'd135: word[MAX_POSITIONS_LOG2-1:0] = move_count;
            14'd136: word = {{16{root_eval[15]}}, root_eval};
            14'd255: word = misc_status;
            default: word = '0;
         endcase
      end
      return word;
   endfunction

   task automatic compare_ports();
      check_value("ctrl", exp_ctrl, ctrl);
      check_value("position", exp_pos, position);
      check_value("move_index", exp_move_index, move_index);
      check_value("half_move", exp_half_move, half_move);
   endtask

   task automatic send_addr(input logic [15:0] addr);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      @(negedge clk);
      while (!awready)
         @(negedge clk);
      @(posedge clk);
      awvalid <= 1'b0;
   endtask

   task automatic send_data(input logic [31:0] data);
      @(posedge clk);
      wdata  <= data;
      wvalid <= 1'b1;
      @(negedge clk);
      while (!wready)
         @(negedge clk);
      @(posedge clk);
      wvalid <= 1'b0;
   endtask

   task automatic send_both(input logic [15:0] addr, input logic [31:0] data);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wvalid  <= 1'b1;
      @(negedge clk);
      while (!(awready && wready))
         @(negedge clk);
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
   endtask

   task automatic write_reg(input logic [13:0] word_addr, input logic [31:0] data);
      logic [31:0] r;
      logic [15:0] byte_addr;
      int          order;
      int          delay;
      r         = lcg_next();
      byte_addr = {word_addr, r[17:16]};   // Byte lane bits are ignored
      order     = rand_below(3);
      delay     = rand_below(6);
      compare_ports();
      apply_write(word_addr, data);
      case (order)
         0:
         begin
            send_addr(byte_addr);
            repeat (rand_below(3)) @(posedge clk);
            send_data(data);
         end
         1:
         begin
            send_data(data);
            repeat (rand_below(3)) @(posedge clk);
            send_addr(byte_addr);
         end
         default: send_both(byte_addr, data);
      endcase
      @(negedge clk);
      while (!bvalid)
         @(negedge clk);
      compare_ports();
      check_value("bresp", 2'b00, bresp);
      repeat (delay)
      begin
         @(negedge clk);
         assert (bvalid) else fail_run("bvalid dropped before bready");
      end
      @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
      @(negedge clk);
      assert (!bvalid) else fail_run("bvalid still high after bready");
      @(negedge clk);
      assert (!bvalid) else fail_run("a second write response for one write");
   endtask

   task automatic check_read(input logic [13:0] word_addr);
      logic [31:0] r;
      r = lcg_next();
      @(posedge clk);
      araddr  <= {word_addr, r[17:16]};
      arvalid <= 1'b1;
      @(posedge clk);
      arvalid <= 1'b0;
      @(negedge clk);
      while (!rvalid)
         @(negedge clk);
      check_value($sformatf("rdata of word %0d", word_addr), expected_read(word_addr), rdata);
      check_value("rresp", 2'b00, rresp);
      check_value("arready", 1'b1, arready);
   endtask

   task automatic check_writeable_regs();
      for (int a = 0; a < 16; a++)
      begin
         if (a < 5 || a >= 8)
            check_read(14'(a));
      end
   endtask

   function automatic logic [13:0] pick_unmapped_addr();
      case (rand_below(4))
         0:       return 14'(5 + rand_below(3));
         1:       return 14'(16 + rand_below(118));
         2:       return 14'(137 + rand_below(118));
         default: return 14'(256 + rand_below(16128));
      endcase
   endfunction

   initial
   begin
      logic [31:0] r;
      logic [31:0] r2;
      rst = 1'b1;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b1;
      status = '0;
      move_count = '0;
      move_eval = '0;
      root_eval = '0;
      misc_status = '0;
      exp_ctrl = '0;
      exp_pos = '0;
      exp_move_index = '0;
      exp_half_move = '0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      // Reset state
      @(negedge clk);
      check_value("awready", 1'b1, awready);
      check_value("wready", 1'b1, wready);
      check_value("bvalid", 1'b0, bvalid);
      check_value("rvalid", 1'b0, rvalid);
      compare_ports();
      check_writeable_regs();

      for (int i = 0; i < 200; i++)
      begin
         r = 32'(rand_below(5));
         write_reg(r[13:0], rand_word());
         check_read(r[13:0]);
      end

      for (int k = 0; k < 8; k++)
         write_reg(14'(8 + k), rand_word());
      check_writeable_regs();

      // Status inputs only move between reads
      for (int i = 0; i < 20; i++)
      begin
         r  = rand_word();
         r2 = rand_word();
         @(posedge clk);
         status      <= status_flags_t'(r[4:0]);
         move_count  <= r[11:5];
         move_eval   <= r[31:16];
         root_eval   <= r2[15:0];
         misc_status <= rand_word();
         check_read(14'd0);
         check_read(14'd134);
         check_read(14'd135);
         check_read(14'd136);
         check_read(14'd255);
      end

      for (int i = 0; i < 30; i++)
      begin
         if (rand_below(2) == 0)
            write_reg(pick_unmapped_addr(), rand_word());
         else
            write_reg(14'(rand_below(2) == 0 ? 134 + rand_below(3) : 255), rand_word());
         if (i % 2 == 0)
            check_read(pick_unmapped_addr());
      end
      check_writeable_regs();

      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* vchess_ctrl.f */
rtl/vchess_ctrl_pkg.sv
rtl/ctrl_axi_write.sv
rtl/ctrl_reg_decode.sv
rtl/ctrl_reg_bank.sv
rtl/ctrl_read_result.sv
rtl/vchess_ctrl_top.sv
sim/tb_vchess_ctrl_chk.sv
sim/tb_vchess_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vchess_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vchess_ctrl \
   -f vchess_ctrl.f -Mdir obj_dir -o tb_vchess_ctrl

./obj_dir/tb_vchess_ctrl 2>&1 | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
